// File: src.f
+incdir+tests
common/lc4_core_pkg.sv
common/lc4_isa_pkg.sv
source/lc4_fetch.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
execute/lc4_alu.sv
execute/lc4_branch_unit.sv
execute/lc4_mem_writeback.sv
source/lc4_core.sv
tests/lc4_core_tb.sv

// File: Makefile
# Verilator flow for the LC4 core testbench

VERILATOR ?= verilator
TOP       ?= lc4_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/lc4_model.svh
// Reference model of the LC4 subset and random program generator, included inside the core testbench
`ifndef LC4_MODEL_SVH
`define LC4_MODEL_SVH

   // Architectural state, updated one instruction at a time
   word_t    m_regs [8];
   nzp_t     m_nzp;
   word_t    m_pc;
   word_t    m_imem [256];
   word_t    m_dmem [256];

   // Expected register writes and stores, oldest first
   reg_sel_t exp_wb_sel [$];
   word_t    exp_wb_data [$];
   word_t    exp_st_addr [$];
   word_t    exp_st_data [$];

   // Arithmetic shift trick for any immediate width
   function automatic word_t sext(input word_t v, input int width);
      logic signed [15:0] s;
      s = $signed(v << (16 - width));
      return word_t'(s >>> (16 - width));
   endfunction

   function automatic nzp_t nzp_of(input word_t v);
      if (v[15]) begin
         return 3'b100;
      end
      if (v == 16'h0000) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   task automatic model_reset();
      for (int i = 0; i < 8; i++) begin
         m_regs[i] = '0;
      end
      m_nzp = '0;
      m_pc  = RESET_PC;
      exp_wb_sel.delete();
      exp_wb_data.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
   endtask

   // Every register write also sets NZP
   task automatic model_write(input reg_sel_t sel, input word_t data);
      m_regs[sel] = data;
      m_nzp       = nzp_of(data);
      exp_wb_sel.push_back(sel);
      exp_wb_data.push_back(data);
   endtask

   task automatic model_step();
      word_t    insn;
      word_t    next_pc;
      word_t    addr;
      reg_sel_t rd;
      reg_sel_t rs;
      reg_sel_t rt;
      insn    = m_imem[m_pc[7:0]];
      rd      = insn[RD_HI:RD_LO];
      rs      = insn[RS_HI:RS_LO];
      rt      = insn[RT_HI:RT_LO];
      next_pc = m_pc + 16'd1;
      case (insn[15:12])
         OP_ARITH: begin
            if (insn[ARITH_IMM_BIT]) begin
               model_write(rd, m_regs[rs] + sext(insn, IMM5_W));
            end else if (insn[5:3] == ARITH_ADD) begin
               model_write(rd, m_regs[rs] + m_regs[rt]);
            end else if (insn[5:3] == ARITH_SUB) begin
               model_write(rd, m_regs[rs] - m_regs[rt]);
            end
         end
         OP_LOGIC: begin
            if (insn[5:3] == LOGIC_AND) begin
               model_write(rd, m_regs[rs] & m_regs[rt]);
            end else if (insn[5:3] == LOGIC_OR) begin
               model_write(rd, m_regs[rs] | m_regs[rt]);
            end else if (insn[5:3] == LOGIC_XOR) begin
               model_write(rd, m_regs[rs] ^ m_regs[rt]);
            end
         end
         OP_LDR: begin
            addr = m_regs[rs] + sext(insn, IMM6_W);
            model_write(rd, m_dmem[addr[7:0]]);
         end
         OP_STR: begin
            // Data register lives in bits 11:9
            addr = m_regs[rs] + sext(insn, IMM6_W);
            m_dmem[addr[7:0]] = m_regs[rd];
            exp_st_addr.push_back(addr);
            exp_st_data.push_back(m_regs[rd]);
         end
         OP_CONST: begin
            model_write(rd, sext(insn, IMM9_W));
         end
         OP_BR: begin
            if ((insn[MASK_HI:MASK_LO] & m_nzp) != 3'b000) begin
               next_pc = m_pc + 16'd1 + sext(insn, IMM9_W);
            end
         end
         default: ;
      endcase
      m_pc = next_pc;
   endtask

   // Mix bits: 0 reg ALU, 1 ADD imm, 2 CONST, 3 LDR, 4 STR, 5 BR
   function automatic word_t gen_insn(input logic [5:0] mix);
      logic [2:0]  kind;
      logic [31:0] r;
      kind = 3'd2;
      for (int i = 0; i < 64; i++) begin
         r = rand_next();
         if (mix[3'(r % 32'd6)]) begin
            kind = 3'(r % 32'd6);
            break;
         end
      end
      r = rand_next();
      case (kind)
         3'd0: begin
            case (r[31:29])
               3'd0, 3'd5: return {OP_ARITH, r[2:0], r[5:3], ARITH_ADD, r[8:6]};
               3'd1:       return {OP_ARITH, r[2:0], r[5:3], ARITH_SUB, r[8:6]};
               3'd2, 3'd6: return {OP_LOGIC, r[2:0], r[5:3], LOGIC_AND, r[8:6]};
               3'd3:       return {OP_LOGIC, r[2:0], r[5:3], LOGIC_OR, r[8:6]};
               default:    return {OP_LOGIC, r[2:0], r[5:3], LOGIC_XOR, r[8:6]};
            endcase
         end
         3'd1:    return {OP_ARITH, r[2:0], r[5:3], 1'b1, r[20:16]};
         3'd3:    return {OP_LDR, r[2:0], r[5:3], r[21:16]};
         3'd4:    return {OP_STR, r[2:0], r[5:3], r[21:16]};
         // Forward only, so the program cannot loop in place
         3'd5:    return {OP_BR, r[14:12], 6'd0, r[18:16]};
         default: return {OP_CONST, r[2:0], r[24:16]};
      endcase
   endfunction

`endif

// File: tests/lc4_core_tb.sv
// Testbench that runs random programs on the LC4 core and checks writebacks and stores against a model
`timescale 1ns/1ns
`default_nettype none

module lc4_core_tb
   import lc4_core_pkg::*;
   import lc4_isa_pkg::*;
();

   localparam word_t RESET_PC     = 16'h8200;
   localparam int    RESET_CYCLES = 16;
   localparam int    RUN_TIMEOUT  = 20000;
   localparam int    STEP_LIMIT   = 1024;

   logic     gwe;
   logic     arst_n;
   word_t    imem_addr;
   word_t    imem_data;
   word_t    dmem_addr;
   logic     dmem_we;
   word_t    dmem_wdata;
   word_t    dmem_rdata;
   logic     wb_valid;
   reg_sel_t wb_sel;
   word_t    wb_data;

   // Memories seen by the DUT and indexed by low address bits
   word_t imem [256];
   word_t dmem [256];

   logic [31:0] rng_state;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;

   lc4_core #(
      .RESET_PC(RESET_PC)
   ) dut0 (
      .gwe         (gwe),
      .i_arst_n    (arst_n),
      .o_imem_addr (imem_addr),
      .i_imem_data (imem_data),
      .o_dmem_addr (dmem_addr),
      .o_dmem_we   (dmem_we),
      .o_dmem_wdata(dmem_wdata),
      .i_dmem_rdata(dmem_rdata),
      .o_wb_valid  (wb_valid),
      .o_wb_sel    (wb_sel),
      .o_wb_data   (wb_data)
   );

   always #10 gwe = ~gwe;

   // Both memories answer one cycle after the address
   always @(posedge gwe) begin
      imem_data  <= imem[imem_addr[7:0]];
      dmem_rdata <= dmem[dmem_addr[7:0]];
      if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_wdata;
      end
   end

   function automatic logic [31:0] rand_next();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

`include "lc4_model.svh"

   task automatic compare_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("Failure at time %0t: %s", $time, what);
      test_errors++;
   endtask

   // Run the model ahead until it has the kind of event just seen
   task automatic fill_expected(input bit want_store);
      int steps;
      steps = 0;
      while ((want_store ? exp_st_addr.size() : exp_wb_sel.size()) == 0 && steps < STEP_LIMIT) begin
         model_step();
         steps++;
      end
      if ((want_store ? exp_st_addr.size() : exp_wb_sel.size()) == 0) begin
         report_failure(want_store ? "DUT stored but the model has no store left"
                                   : "DUT wrote a register but the model has no write left");
      end
   endtask

   task automatic load_program(input logic [5:0] mix);
      for (int i = 0; i < 256; i++) begin
         m_imem[i] = gen_insn(mix);
         imem[i]   = m_imem[i];
         m_dmem[i] = word_t'(rand_next());
         dmem[i]   = m_dmem[i];
      end
   endtask

   task automatic run_test(input string name, input logic [5:0] mix, input int n_events);
      int events;
      int cycles;
      test_errors = 0;
      @(posedge gwe);
      arst_n <= 1'b0;
      @(negedge gwe);
      load_program(mix);
      model_reset();
      // Nothing may be written while reset is held
      // First reset cycle is spent loading the memories
      for (int i = 1; i < RESET_CYCLES; i++) begin
         @(negedge gwe);
         compare_value("o_wb_valid", 16'(wb_valid), 16'h0);
         compare_value("o_dmem_we", 16'(dmem_we), 16'h0);
      end
      @(posedge gwe);
      arst_n <= 1'b1;
      @(negedge gwe);
      compare_value("o_imem_addr", imem_addr, 16'h8200);
      events = 0;
      cycles = 0;
      while (events < n_events && cycles < RUN_TIMEOUT) begin
         @(negedge gwe);
         cycles++;
         if (wb_valid) begin
            fill_expected(1'b0);
            if (exp_wb_sel.size() > 0) begin
               compare_value("o_wb_sel", 16'(wb_sel), 16'(exp_wb_sel.pop_front()));
               compare_value("o_wb_data", wb_data, exp_wb_data.pop_front());
            end
            events++;
         end
         if (dmem_we) begin
            fill_expected(1'b1);
            if (exp_st_addr.size() > 0) begin
               compare_value("o_dmem_addr", dmem_addr, exp_st_addr.pop_front());
               compare_value("o_dmem_wdata", dmem_wdata, exp_st_data.pop_front());
            end
            events++;
         end
      end
      if (events < n_events) begin
         report_failure($sformatf("%s ran out of time after %0d events", name, events));
      end
      $display("Test %s: %0d events, %0d errors", name, events, test_errors);
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0) begin
         tests_failed++;
      end
   endtask

   initial begin
      gwe          = 1'b0;
      arst_n       = 1'b0;
      imem_data    = '0;
      dmem_rdata   = '0;
      rng_state    = 32'h10d82b80;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      // CONST seeds nonzero values for the register ops
      run_test("register_alu", 6'b000101, 400);
      run_test("immediates", 6'b000110, 400);
      run_test("load_store", 6'b011111, 400);
      run_test("branches", 6'b100111, 400);
      run_test("mixed", 6'b111111, 600);
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/lc4_core.sv
// Top of the three-stage LC4 core, connects fetch, execute units and writeback
`timescale 1ns/1ns
`default_nettype none

module lc4_core
   import lc4_core_pkg::*;
#(
   parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
   input  logic     gwe,
   input  logic     i_arst_n,
   output word_t    o_imem_addr,
   input  word_t    i_imem_data,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   input  word_t    i_dmem_rdata,
   output logic     o_wb_valid,
   output reg_sel_t o_wb_sel,
   output word_t    o_wb_data
);

   // Fetch to execute
   logic     x_valid;
   word_t    x_pc;
   logic     redirect;
   word_t    redirect_pc;

   // Decoded controls
   alu_op_e  alu_op;
   reg_sel_t rs_sel;
   reg_sel_t rt_sel;
   reg_sel_t rd_sel;
   word_t    imm;
   logic     use_imm;
   logic     reg_we;
   logic     is_load;
   logic     is_store;
   logic     is_branch;
   nzp_t     br_mask;

   // Operands and results
   word_t    rs_data;
   word_t    rt_data;
   word_t    alu_result;
   nzp_t     nzp;

   lc4_fetch #(
      .RESET_PC(RESET_PC)
   ) fetch0 (
      .gwe          (gwe),
      .i_arst_n     (i_arst_n),
      .i_redirect   (redirect),
      .i_redirect_pc(redirect_pc),
      .o_imem_addr  (o_imem_addr),
      .o_x_valid    (x_valid),
      .o_x_pc       (x_pc)
   );

   // Memory output is the execute-stage instruction
   lc4_decoder dec0 (
      .i_insn     (i_imem_data),
      .o_alu_op   (alu_op),
      .o_rs_sel   (rs_sel),
      .o_rt_sel   (rt_sel),
      .o_rd_sel   (rd_sel),
      .o_imm      (imm),
      .o_use_imm  (use_imm),
      .o_reg_we   (reg_we),
      .o_is_load  (is_load),
      .o_is_store (is_store),
      .o_is_branch(is_branch),
      .o_br_mask  (br_mask)
   );

   // Write port fed back from writeback
   lc4_regfile rf0 (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_rs_sel (rs_sel),
      .i_rt_sel (rt_sel),
      .o_rs_data(rs_data),
      .o_rt_data(rt_data),
      .i_rd_sel (o_wb_sel),
      .i_rd_we  (o_wb_valid),
      .i_rd_data(o_wb_data)
   );

   lc4_alu alu0 (
      .i_alu_op (alu_op),
      .i_rs_data(rs_data),
      .i_rt_data(rt_data),
      .i_imm    (imm),
      .i_use_imm(use_imm),
      .o_result (alu_result)
   );

   lc4_branch_unit br0 (
      .i_x_valid    (x_valid),
      .i_is_branch  (is_branch),
      .i_br_mask    (br_mask),
      .i_nzp        (nzp),
      .i_pc         (x_pc),
      .i_imm        (imm),
      .o_redirect   (redirect),
      .o_redirect_pc(redirect_pc)
   );

   lc4_mem_writeback mwb0 (
      .gwe         (gwe),
      .i_arst_n    (i_arst_n),
      .i_x_valid   (x_valid),
      .i_reg_we    (reg_we),
      .i_is_load   (is_load),
      .i_is_store  (is_store),
      .i_rd_sel    (rd_sel),
      .i_alu_result(alu_result),
      .i_rt_data   (rt_data),
      .i_dmem_rdata(i_dmem_rdata),
      .o_dmem_addr (o_dmem_addr),
      .o_dmem_we   (o_dmem_we),
      .o_dmem_wdata(o_dmem_wdata),
      .o_wb_valid  (o_wb_valid),
      .o_wb_sel    (o_wb_sel),
      .o_wb_data   (o_wb_data),
      .o_nzp       (nzp)
   );

endmodule

`default_nettype wire

// File: execute/lc4_mem_writeback.sv
// Data memory request in execute, then the writeback register, result select and NZP state
`timescale 1ns/1ns
`default_nettype none

module lc4_mem_writeback
   import lc4_core_pkg::*;
(
   input  logic     gwe,
   input  logic     i_arst_n,
   input  logic     i_x_valid,
   input  logic     i_reg_we,
   input  logic     i_is_load,
   input  logic     i_is_store,
   input  reg_sel_t i_rd_sel,
   input  word_t    i_alu_result,
   input  word_t    i_rt_data,
   input  word_t    i_dmem_rdata,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   output logic     o_wb_valid,
   output reg_sel_t o_wb_sel,
   output word_t    o_wb_data,
   output nzp_t     o_nzp
);

   logic     mem_access;
   logic     w_valid_q;
   reg_sel_t w_sel_q;
   word_t    w_result_q;
   logic     w_is_load_q;
   nzp_t     nzp_q;
   nzp_t     nzp_next;

   // Request leaves in the execute cycle and data comes back in writeback
   assign mem_access   = i_x_valid && (i_is_load || i_is_store);
   assign o_dmem_addr  = mem_access ? i_alu_result : '0;
   assign o_dmem_we    = i_x_valid && i_is_store;
   assign o_dmem_wdata = i_rt_data;

   // Writeback valid bit, low through reset
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         w_valid_q <= 1'b0;
      end else begin
         w_valid_q <= i_x_valid && i_reg_we;
      end
   end

   always_ff @(posedge gwe) begin
      w_sel_q     <= i_rd_sel;
      w_result_q  <= i_alu_result;
      w_is_load_q <= i_is_load;
   end

   // Load data replaces the address held from execute
   assign o_wb_valid = w_valid_q;
   assign o_wb_sel   = w_sel_q;
   assign o_wb_data  = w_is_load_q ? i_dmem_rdata : w_result_q;

   // Sign and zero of the written value
   assign nzp_next = {o_wb_data[15], o_wb_data == '0, !o_wb_data[15] && o_wb_data != '0};

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         nzp_q <= '0;
      end else if (w_valid_q) begin
         nzp_q <= nzp_next;
      end
   end

   // Branch in execute sees the NZP being written this cycle
   assign o_nzp = w_valid_q ? nzp_next : nzp_q;

endmodule

`default_nettype wire

// File: execute/lc4_branch_unit.sv
// Branch resolution in execute, tests NZP against the mask and sends the redirect to fetch
`timescale 1ns/1ns
`default_nettype none

module lc4_branch_unit
   import lc4_core_pkg::*;
(
   input  logic  i_x_valid,
   input  logic  i_is_branch,
   input  nzp_t  i_br_mask,
   input  nzp_t  i_nzp,
   input  word_t i_pc,
   input  word_t i_imm,
   output logic  o_redirect,
   output word_t o_redirect_pc
);

   // Any shared bit takes the branch
   // NZP here already includes the writeback result
   assign o_redirect = i_x_valid && i_is_branch && ((i_br_mask & i_nzp) != 3'b000);

   // Offset is relative to the next instruction
   assign o_redirect_pc = i_pc + 16'd1 + i_imm;

endmodule

`default_nettype wire

// File: execute/lc4_alu.sv
// Execute ALU, picks the second operand and computes the result or the memory address
`timescale 1ns/1ns
`default_nettype none

module lc4_alu
   import lc4_core_pkg::*;
(
   input  alu_op_e i_alu_op,
   input  word_t   i_rs_data,
   input  word_t   i_rt_data,
   input  word_t   i_imm,
   input  logic    i_use_imm,
   output word_t   o_result
);

   word_t op_b;
   logic  sub;
   word_t sum;

   assign op_b = i_use_imm ? i_imm : i_rt_data;

   // One adder for ADD, SUB and load/store addresses
   // Subtract as a plus inverted b plus one
   assign sub = (i_alu_op == ALU_SUB);
   assign sum = i_rs_data + (sub ? ~op_b : op_b) + {15'd0, sub};

   always_comb begin
      case (i_alu_op)
         ALU_ADD,
         ALU_SUB:      o_result = sum;
         ALU_AND:      o_result = i_rs_data & op_b;
         ALU_OR:       o_result = i_rs_data | op_b;
         ALU_XOR:      o_result = i_rs_data ^ op_b;
         // CONST just forwards the extended immediate
         ALU_PASS_IMM: o_result = op_b;
         default:      o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: source/lc4_regfile.sv
// Register file with two combinational read ports and write-through from the writeback port
`timescale 1ns/1ns
`default_nettype none

module lc4_regfile
   import lc4_core_pkg::*;
(
   input  logic     gwe,
   input  logic     i_arst_n,
   input  reg_sel_t i_rs_sel,
   input  reg_sel_t i_rt_sel,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  reg_sel_t i_rd_sel,
   input  logic     i_rd_we,
   input  word_t    i_rd_data
);

   word_t regs [NUM_REGS];

   // Architectural state starts at zero
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // Bypass the value being written this cycle
   // Covers back-to-back ALU and load-use dependences
   assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

`default_nettype wire

// File: source/lc4_decoder.sv
// Combinational decoder, turns the execute-stage instruction into selectors, immediate and control
`timescale 1ns/1ns
`default_nettype none

module lc4_decoder
   import lc4_core_pkg::*;
   import lc4_isa_pkg::*;
(
   input  word_t    i_insn,
   output alu_op_e  o_alu_op,
   output reg_sel_t o_rs_sel,
   output reg_sel_t o_rt_sel,
   output reg_sel_t o_rd_sel,
   output word_t    o_imm,
   output logic     o_use_imm,
   output logic     o_reg_we,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_branch,
   output nzp_t     o_br_mask
);

   opcode_e    opcode;
   logic [2:0] sub_op;
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;

   assign opcode = opcode_e'(i_insn[OPCODE_HI:OPCODE_LO]);
   assign sub_op = i_insn[SUBOP_HI:SUBOP_LO];

   // Sign extension of the three immediate forms
   assign imm5 = {{(16 - IMM5_W){i_insn[IMM5_W-1]}}, i_insn[IMM5_W-1:0]};
   assign imm6 = {{(16 - IMM6_W){i_insn[IMM6_W-1]}}, i_insn[IMM6_W-1:0]};
   assign imm9 = {{(16 - IMM9_W){i_insn[IMM9_W-1]}}, i_insn[IMM9_W-1:0]};

   // Fixed field positions
   assign o_rs_sel  = i_insn[RS_HI:RS_LO];
   assign o_rd_sel  = i_insn[RD_HI:RD_LO];
   assign o_br_mask = i_insn[MASK_HI:MASK_LO];
   // Store data register sits in the rd slot
   assign o_rt_sel  = o_is_store ? i_insn[RD_HI:RD_LO] : i_insn[RT_HI:RT_LO];

   always_comb begin
      // Default is a NOP that writes nothing
      o_alu_op    = ALU_ADD;
      o_imm       = imm6;
      o_use_imm   = 1'b0;
      o_reg_we    = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      case (opcode)
         OP_ARITH: begin
            if (i_insn[ARITH_IMM_BIT]) begin
               o_imm     = imm5;
               o_use_imm = 1'b1;
               o_reg_we  = 1'b1;
            end else if (sub_op == ARITH_ADD) begin
               o_reg_we = 1'b1;
            end else if (sub_op == ARITH_SUB) begin
               o_alu_op = ALU_SUB;
               o_reg_we = 1'b1;
            end
         end
         OP_LOGIC: begin
            // NOT and AND-immediate fall through as NOP
            case (sub_op)
               LOGIC_AND: begin
                  o_alu_op = ALU_AND;
                  o_reg_we = 1'b1;
               end
               LOGIC_OR: begin
                  o_alu_op = ALU_OR;
                  o_reg_we = 1'b1;
               end
               LOGIC_XOR: begin
                  o_alu_op = ALU_XOR;
                  o_reg_we = 1'b1;
               end
               default: ;
            endcase
         end
         OP_LDR: begin
            // Address is rs plus offset through the adder
            o_use_imm = 1'b1;
            o_reg_we  = 1'b1;
            o_is_load = 1'b1;
         end
         OP_STR: begin
            o_use_imm  = 1'b1;
            o_is_store = 1'b1;
         end
         OP_CONST: begin
            o_alu_op  = ALU_PASS_IMM;
            o_imm     = imm9;
            o_use_imm = 1'b1;
            o_reg_we  = 1'b1;
         end
         OP_BR: begin
            // Empty mask never matches, so it acts as NOP
            o_imm       = imm9;
            o_is_branch = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: source/lc4_fetch.sv
// Fetch stage, owns the PC and tags the instruction returning from memory with its PC and valid bit
`timescale 1ns/1ns
`default_nettype none

module lc4_fetch
   import lc4_core_pkg::*;
#(
   parameter word_t RESET_PC = RESET_PC_DEFAULT
) (
   input  logic  gwe,
   input  logic  i_arst_n,
   input  logic  i_redirect,
   input  word_t i_redirect_pc,
   output word_t o_imem_addr,
   output logic  o_x_valid,
   output word_t o_x_pc
);

   word_t pc_q;
   logic  x_valid_q;
   word_t x_pc_q;

   // PC goes out directly as the memory address
   // Redirect wins over the sequential step
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q      <= RESET_PC;
         x_valid_q <= 1'b0;
      end else begin
         pc_q      <= i_redirect ? i_redirect_pc : pc_q + 16'd1;
         // Word fetched alongside a redirect is wrong path
         x_valid_q <= !i_redirect;
      end
   end

   // Address sampled by memory at this edge, so it pairs with next cycle's data
   always_ff @(posedge gwe) begin
      x_pc_q <= pc_q;
   end

   assign o_imem_addr = pc_q;
   assign o_x_valid   = x_valid_q;
   assign o_x_pc      = x_pc_q;

endmodule

`default_nettype wire

// File: common/lc4_isa_pkg.sv
// LC4 instruction encodings and field positions, imported by the decoder and the testbench
`default_nettype none

package lc4_isa_pkg;

   // Top four bits of every instruction
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   localparam int OPCODE_HI = 15;
   localparam int OPCODE_LO = 12;

   // Register fields; STR keeps its data register in the rd slot
   localparam int RD_HI = 11;
   localparam int RD_LO = 9;
   localparam int RS_HI = 8;
   localparam int RS_LO = 6;
   localparam int RT_HI = 2;
   localparam int RT_LO = 0;

   // Branch condition mask
   localparam int MASK_HI = 11;
   localparam int MASK_LO = 9;

   // Sub-op of the register forms
   localparam int SUBOP_HI = 5;
   localparam int SUBOP_LO = 3;
   // Set for ADD with immediate
   localparam int ARITH_IMM_BIT = 5;

   // Immediate widths, all sign-extended
   localparam int IMM5_W = 5;
   localparam int IMM6_W = 6;
   localparam int IMM9_W = 9;

   // Sub-op codes
   localparam logic [2:0] ARITH_ADD = 3'b000;
   localparam logic [2:0] ARITH_SUB = 3'b010;
   localparam logic [2:0] LOGIC_AND = 3'b000;
   localparam logic [2:0] LOGIC_OR  = 3'b010;
   localparam logic [2:0] LOGIC_XOR = 3'b011;

endpackage

`default_nettype wire

// File: common/lc4_core_pkg.sv
// Datapath types, ALU operations and core defaults, imported by the core modules
`default_nettype none

package lc4_core_pkg;

   // One data or address word
   typedef logic [15:0] word_t;

   // Register index
   typedef logic [2:0] reg_sel_t;

   // Condition codes, {negative, zero, positive}
   typedef logic [2:0] nzp_t;

   // Operations of the execute ALU
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM
   } alu_op_e;

   // First fetch address after reset
   localparam logic [15:0] RESET_PC_DEFAULT = 16'h8200;

   localparam int NUM_REGS = 8;

endpackage

`default_nettype wire
